// File: src/alloc_pkg.sv
package alloc_pkg;

    ////////////////////////////////////////////////////////////
    // sizes.
    ////////////////////////////////////////////////////////////

    // architectural register file.
    localparam int num_arch_regs = 32;
    localparam int reg_addr_w    = 5;

    // reorder buffer.
    localparam int num_rob  = 16;
    localparam int rob_id_w = 4;

    // load queue.
    localparam int num_ldq  = 8;
    localparam int ldq_id_w = 3;

    // store queue.
    localparam int num_stq  = 8;
    localparam int stq_id_w = 3;

    ////////////////////////////////////////////////////////////
    // micro-op classes.
    ////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        op_alu    = 2'd0,
        op_load   = 2'd1,
        op_store  = 2'd2,
        op_branch = 2'd3
    } t_opcode;

    // takes a load queue entry.
    function automatic logic is_load(input t_opcode op);
        return op == op_load;
    endfunction

    // takes a store queue entry.
    function automatic logic is_store(input t_opcode op);
        return op == op_store;
    endfunction

endpackage

// File: src/rename.sv
module rename (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             nuke,
    input  logic                             accept,
    input  alloc_pkg::t_opcode               opcode,
    input  logic [alloc_pkg::reg_addr_w-1:0] dst,
    input  logic [alloc_pkg::reg_addr_w-1:0] src1,
    input  logic [alloc_pkg::reg_addr_w-1:0] src2,
    input  logic                             rob_free,
    output logic [alloc_pkg::rob_id_w-1:0]   robid,
    output logic [alloc_pkg::rob_id_w-1:0]   psrc1,
    output logic                             psrc1_pdg,
    output logic [alloc_pkg::rob_id_w-1:0]   psrc2,
    output logic                             psrc2_pdg,
    output logic                             rob_full
);
    import alloc_pkg::*;

    ////////////////////////////////////////////////////////////
    // register alias table.
    ////////////////////////////////////////////////////////////

    // youngest producer of each register.
    logic [rob_id_w-1:0]      rat_id [num_arch_regs];
    logic [num_arch_regs-1:0] rat_pdg;

    logic rat_wr;

    // r0 is hardwired, it never gets a producer.
    assign rat_wr = accept && (dst != '0);

    always_ff @(posedge clk) begin
        if (rat_wr) begin
            rat_id[dst] <= robid;
        end
    end

    // no writeback here, so only a flush clears pending.
    always_ff @(posedge clk) begin
        if (reset || nuke) begin
            rat_pdg <= '0;
        end else if (rat_wr) begin
            rat_pdg[dst] <= 1'b1;
        end
    end

    // sources see the table before this op's own write.
    always_comb begin
        psrc1_pdg = rat_pdg[src1];
        psrc2_pdg = rat_pdg[src2];
        psrc1     = psrc1_pdg ? rat_id[src1] : '0;
        psrc2     = psrc2_pdg ? rat_id[src2] : '0;
    end

    ////////////////////////////////////////////////////////////
    // reorder buffer ids.
    ////////////////////////////////////////////////////////////

    // pointers carry one extra wrap bit.
    logic [rob_id_w:0] rob_head;
    logic [rob_id_w:0] rob_tail;
    logic [rob_id_w:0] rob_count;

    assign rob_count = rob_tail - rob_head;
    assign rob_full  = (rob_count == (rob_id_w + 1)'(num_rob));
    assign robid     = rob_tail[rob_id_w-1:0];

    always_ff @(posedge clk) begin
        if (reset || nuke) begin
            rob_head <= '0;
            rob_tail <= '0;
        end else begin
            if (accept) begin
                rob_tail <= rob_tail + 1'b1;
            end
            // retire is in order.
            if (rob_free) begin
                rob_head <= rob_head + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // checks.
    ////////////////////////////////////////////////////////////

    // alloc must hold off while the rob is full.
    a_no_accept_full: assert property (
        @(posedge clk) disable iff (reset)
        accept |-> !rob_full
    );

    a_no_free_empty: assert property (
        @(posedge clk) disable iff (reset)
        rob_free |-> (rob_count != '0)
    );

    // an accepted uop must be fully driven.
    a_known_uop: assert property (
        @(posedge clk) disable iff (reset)
        accept |-> !$isunknown({opcode, dst, src1, src2})
    );

endmodule

// File: src/mem_id_trk.sv
module mem_id_trk (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           nuke,
    input  logic                           ld_alloc,
    input  logic                           st_alloc,
    input  logic                           ldq_free,
    input  logic                           stq_free,
    output logic [alloc_pkg::ldq_id_w-1:0] ldq_id,
    output logic [alloc_pkg::stq_id_w-1:0] stq_id,
    output logic                           ldq_full,
    output logic                           stq_full
);
    import alloc_pkg::*;

    // queue 0 is the load queue, queue 1 the store queue.
    for (genvar q = 0; q < 2; q++) begin : g_q
        localparam int depth = (q == 0) ? num_ldq : num_stq;
        localparam int id_w  = (q == 0) ? ldq_id_w : stq_id_w;

        logic            do_alloc;
        logic            do_free;
        logic            full;
        logic [id_w-1:0] tail;
        logic [id_w:0]   cnt;

        assign do_alloc = (q == 0) ? ld_alloc : st_alloc;
        assign do_free  = (q == 0) ? ldq_free : stq_free;
        assign full     = (cnt == (id_w + 1)'(depth));

        always_ff @(posedge clk) begin
            if (reset || nuke) begin
                tail <= '0;
                cnt  <= '0;
            end else begin
                if (do_alloc) begin
                    tail <= (tail == id_w'(depth - 1)) ? '0 : tail + 1'b1;
                end
                // alloc and free together leave the count alone.
                case ({do_alloc, do_free})
                    2'b10:   cnt <= cnt + 1'b1;
                    2'b01:   cnt <= cnt - 1'b1;
                    default: cnt <= cnt;
                endcase
            end
        end

        if (q == 0) begin : g_ld
            assign ldq_id   = tail;
            assign ldq_full = full;
        end else begin : g_st
            assign stq_id   = tail;
            assign stq_full = full;
        end

        a_no_alloc_full: assert property (
            @(posedge clk) disable iff (reset)
            do_alloc |-> !full
        );
    end

endmodule

// File: src/alloc.sv
module alloc (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           nuke,

    // incoming uop.
    input  logic                           valid,
    input  alloc_pkg::t_opcode             opcode,
    output logic                           ready,

    // stall sources.
    input  logic                           rs_stall,
    input  logic                           rob_full,
    input  logic                           ldq_full,
    input  logic                           stq_full,

    // rename and memory id results.
    input  logic [alloc_pkg::rob_id_w-1:0] robid,
    input  logic [alloc_pkg::rob_id_w-1:0] psrc1,
    input  logic                           psrc1_pdg,
    input  logic [alloc_pkg::rob_id_w-1:0] psrc2,
    input  logic                           psrc2_pdg,
    input  logic [alloc_pkg::ldq_id_w-1:0] ldq_id,
    input  logic [alloc_pkg::stq_id_w-1:0] stq_id,

    // allocation pulses.
    output logic                           accept,
    output logic                           ld_alloc,
    output logic                           st_alloc,

    // dispatch packet.
    output logic                           disp_valid,
    output alloc_pkg::t_opcode             disp_opcode,
    output logic [alloc_pkg::rob_id_w-1:0] disp_robid,
    output logic [alloc_pkg::rob_id_w-1:0] disp_psrc1,
    output logic                           disp_psrc1_pdg,
    output logic [alloc_pkg::rob_id_w-1:0] disp_psrc2,
    output logic                           disp_psrc2_pdg,
    output logic [alloc_pkg::ldq_id_w-1:0] disp_ldqid,
    output logic [alloc_pkg::stq_id_w-1:0] disp_stqid
);
    import alloc_pkg::*;

    logic stage_vld;
    logic mem_op;

    ////////////////////////////////////////////////////////////
    // input side.
    ////////////////////////////////////////////////////////////

    // room when empty or draining, and nothing downstream is full.
    assign ready = !nuke && (!stage_vld || !rs_stall)
                   && !rob_full && !ldq_full && !stq_full;

    assign accept   = valid && ready;
    assign ld_alloc = accept && is_load(opcode);
    assign st_alloc = accept && is_store(opcode);

    // loads and stores both carry the two queue tails for ordering.
    assign mem_op = is_load(opcode) || is_store(opcode);

    ////////////////////////////////////////////////////////////
    // stage register.
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset || nuke) begin
            stage_vld <= 1'b0;
        end else if (accept) begin
            stage_vld <= 1'b1;
        end else if (!rs_stall) begin
            stage_vld <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            disp_opcode    <= opcode;
            disp_robid     <= robid;
            disp_psrc1     <= psrc1;
            disp_psrc1_pdg <= psrc1_pdg;
            disp_psrc2     <= psrc2;
            disp_psrc2_pdg <= psrc2_pdg;
            disp_ldqid     <= mem_op ? ldq_id : '0;
            disp_stqid     <= mem_op ? stq_id : '0;
        end
    end

    // a flush hides the held packet right away.
    assign disp_valid = stage_vld && !nuke;

    // held packet must not move under a reservation station stall.
    a_hold_stable: assert property (
        @(posedge clk) disable iff (reset)
        (disp_valid && rs_stall) |=>
            $stable({disp_opcode, disp_robid, disp_psrc1, disp_psrc1_pdg,
                     disp_psrc2, disp_psrc2_pdg, disp_ldqid, disp_stqid})
    );

endmodule

// File: src/alloc_top.sv
module alloc_top (
    input  logic                             clk,
    input  logic                             reset,

    input  logic                             valid,
    input  alloc_pkg::t_opcode               opcode,
    input  logic [alloc_pkg::reg_addr_w-1:0] dst,
    input  logic [alloc_pkg::reg_addr_w-1:0] src1,
    input  logic [alloc_pkg::reg_addr_w-1:0] src2,
    output logic                             ready,

    input  logic                             rs_stall,
    input  logic                             nuke,
    input  logic                             rob_free,
    input  logic                             ldq_free,
    input  logic                             stq_free,

    output logic                             disp_valid,
    output alloc_pkg::t_opcode               disp_opcode,
    output logic [alloc_pkg::rob_id_w-1:0]   disp_robid,
    output logic [alloc_pkg::rob_id_w-1:0]   disp_psrc1,
    output logic                             disp_psrc1_pdg,
    output logic [alloc_pkg::rob_id_w-1:0]   disp_psrc2,
    output logic                             disp_psrc2_pdg,
    output logic [alloc_pkg::ldq_id_w-1:0]   disp_ldqid,
    output logic [alloc_pkg::stq_id_w-1:0]   disp_stqid
);
    import alloc_pkg::*;

    logic                accept;
    logic                ld_alloc;
    logic                st_alloc;
    logic [rob_id_w-1:0] robid;
    logic [rob_id_w-1:0] psrc1;
    logic                psrc1_pdg;
    logic [rob_id_w-1:0] psrc2;
    logic                psrc2_pdg;
    logic                rob_full;
    logic [ldq_id_w-1:0] ldq_id;
    logic [stq_id_w-1:0] stq_id;
    logic                ldq_full;
    logic                stq_full;

    rename i_rename (
        .clk, .reset, .nuke, .accept, .opcode, .dst, .src1, .src2, .rob_free,
        .robid, .psrc1, .psrc1_pdg, .psrc2, .psrc2_pdg, .rob_full
    );

    mem_id_trk i_mem_id_trk (
        .clk, .reset, .nuke, .ld_alloc, .st_alloc, .ldq_free, .stq_free,
        .ldq_id, .stq_id, .ldq_full, .stq_full
    );

    alloc i_alloc (
        .clk, .reset, .nuke,
        .valid, .opcode, .ready,
        .rs_stall, .rob_full, .ldq_full, .stq_full,
        .robid, .psrc1, .psrc1_pdg, .psrc2, .psrc2_pdg, .ldq_id, .stq_id,
        .accept, .ld_alloc, .st_alloc,
        .disp_valid, .disp_opcode, .disp_robid,
        .disp_psrc1, .disp_psrc1_pdg, .disp_psrc2, .disp_psrc2_pdg,
        .disp_ldqid, .disp_stqid
    );

endmodule

// File: tb/alloc_ref.svh
`ifndef alloc_ref_svh
`define alloc_ref_svh

////////////////////////////////////////////////////////////
// expected dispatch packet.
////////////////////////////////////////////////////////////

typedef struct packed {
    t_opcode             opcode;
    logic [rob_id_w-1:0] robid;
    logic [rob_id_w-1:0] psrc1;
    logic                psrc1_pdg;
    logic [rob_id_w-1:0] psrc2;
    logic                psrc2_pdg;
    logic [ldq_id_w-1:0] ldqid;
    logic [stq_id_w-1:0] stqid;
} t_exp_pkt;

// expected alias table.
logic [rob_id_w-1:0]      ref_rat_id [num_arch_regs];
logic [num_arch_regs-1:0] ref_pdg;

// id tails and occupancy of the three structures.
int ref_rob_tail;
int ref_rob_cnt;
int ref_ldq_tail;
int ref_ldq_cnt;
int ref_stq_tail;
int ref_stq_cnt;

// accepted ops that are not dispatched yet.
t_exp_pkt ref_q[$];

function automatic void ref_clear();
    ref_pdg      = '0;
    ref_rob_tail = 0;
    ref_rob_cnt  = 0;
    ref_ldq_tail = 0;
    ref_ldq_cnt  = 0;
    ref_stq_tail = 0;
    ref_stq_cnt  = 0;
    ref_q.delete();
endfunction

// ready before this edge's updates.
function automatic logic ref_ready(input logic stall, input logic flush);
    return !flush && (ref_q.size() == 0 || !stall) && (ref_rob_cnt < num_rob)
           && (ref_ldq_cnt < num_ldq) && (ref_stq_cnt < num_stq);
endfunction

function automatic t_exp_pkt ref_packet(input t_opcode op,
                                        input logic [reg_addr_w-1:0] s1,
                                        input logic [reg_addr_w-1:0] s2);
    t_exp_pkt p;
    logic     mem;
    mem         = (op == op_load) || (op == op_store);
    p.opcode    = op;
    p.robid     = rob_id_w'(ref_rob_tail);
    p.psrc1_pdg = ref_pdg[s1];
    p.psrc1     = ref_pdg[s1] ? ref_rat_id[s1] : '0;
    p.psrc2_pdg = ref_pdg[s2];
    p.psrc2     = ref_pdg[s2] ? ref_rat_id[s2] : '0;
    // memory ops carry both queue tails.
    p.ldqid     = mem ? ldq_id_w'(ref_ldq_tail) : '0;
    p.stqid     = mem ? stq_id_w'(ref_stq_tail) : '0;
    return p;
endfunction

// sources are looked up before the destination is renamed.
function automatic void ref_accept(input t_opcode op,
                                   input logic [reg_addr_w-1:0] d,
                                   input logic [reg_addr_w-1:0] s1,
                                   input logic [reg_addr_w-1:0] s2);
    ref_q.push_back(ref_packet(op, s1, s2));
    if (d != 0) begin
        ref_rat_id[d] = rob_id_w'(ref_rob_tail);
        ref_pdg[d]    = 1'b1;
    end
    ref_rob_tail = (ref_rob_tail + 1) % num_rob;
    ref_rob_cnt++;
    if (op == op_load) begin
        ref_ldq_tail = (ref_ldq_tail + 1) % num_ldq;
        ref_ldq_cnt++;
    end
    if (op == op_store) begin
        ref_stq_tail = (ref_stq_tail + 1) % num_stq;
        ref_stq_cnt++;
    end
endfunction

function automatic void ref_free(input logic rf, input logic lf, input logic sf);
    if (rf) begin
        ref_rob_cnt--;
    end
    if (lf) begin
        ref_ldq_cnt--;
    end
    if (sf) begin
        ref_stq_cnt--;
    end
endfunction

`endif

// File: tb/alloc_tb.sv
module alloc_tb;
    import alloc_pkg::*;

    localparam int clk_period    = 100;
    localparam int run_seed      = 12884;
    localparam int accept_limit  = 100;
    localparam int drain_limit   = 40;
    localparam int random_cycles = 400;
    // rough cycle budget of tests 1 to 5, then the random mix and the drains.
    localparam int test_cycles     = 40 + 120 + 300 + 120 + 40 + random_cycles
                                     + 7 * drain_limit;
    localparam int watchdog_cycles = 4 + test_cycles + 500;

    logic                  clk = 1'b0;
    logic                  reset;
    logic                  valid;
    t_opcode               opcode;
    logic [reg_addr_w-1:0] dst;
    logic [reg_addr_w-1:0] src1;
    logic [reg_addr_w-1:0] src2;
    logic                  ready;
    logic                  rs_stall;
    logic                  nuke;
    logic                  rob_free;
    logic                  ldq_free;
    logic                  stq_free;
    logic                  disp_valid;
    t_opcode               disp_opcode;
    logic [rob_id_w-1:0]   disp_robid;
    logic [rob_id_w-1:0]   disp_psrc1;
    logic                  disp_psrc1_pdg;
    logic [rob_id_w-1:0]   disp_psrc2;
    logic                  disp_psrc2_pdg;
    logic [ldq_id_w-1:0]   disp_ldqid;
    logic [stq_id_w-1:0]   disp_stqid;

    int   errors      = 0;
    int   test_errors = 0;
    int   checks      = 0;
    logic took        = 1'b0;
    logic stall_rand  = 1'b0;
    logic stall_force = 1'b0;
    logic stall_on    = 1'b0;
    int   stall_left  = 0;

    `include "alloc_ref.svh"

    alloc_top i_alloc_top (.*);

    always #(clk_period / 2) clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %0h expected %0h", $time, name, got, exp);
            errors++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // comparison against the reference model.
    ////////////////////////////////////////////////////////////

    always @(posedge clk) begin : compare
        t_exp_pkt exp_pkt;
        logic     exp_ready;
        if (reset) begin
            ref_clear();
        end else begin
            exp_ready = ref_ready(rs_stall, nuke);
            check_value("ready", ready, exp_ready);
            check_value("disp_valid", disp_valid, (ref_q.size() != 0) && !nuke);
            if (nuke) begin
                ref_clear();
            end else begin
                if (disp_valid && !rs_stall) begin
                    if (ref_q.size() == 0) begin
                        $display("%0t: a packet was dispatched with no accepted op behind it",
                                 $time);
                        errors++;
                    end else begin
                        exp_pkt = ref_q.pop_front();
                        check_value("disp_opcode", disp_opcode, exp_pkt.opcode);
                        check_value("disp_robid", disp_robid, exp_pkt.robid);
                        check_value("disp_psrc1", disp_psrc1, exp_pkt.psrc1);
                        check_value("disp_psrc1_pdg", disp_psrc1_pdg, exp_pkt.psrc1_pdg);
                        check_value("disp_psrc2", disp_psrc2, exp_pkt.psrc2);
                        check_value("disp_psrc2_pdg", disp_psrc2_pdg, exp_pkt.psrc2_pdg);
                        check_value("disp_ldqid", disp_ldqid, exp_pkt.ldqid);
                        check_value("disp_stqid", disp_stqid, exp_pkt.stqid);
                    end
                end
                ref_free(rob_free, ldq_free, stq_free);
                if (valid && exp_ready) begin
                    ref_accept(opcode, dst, src1, src2);
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus helpers.
    ////////////////////////////////////////////////////////////

    task automatic drive_stall();
        if (stall_left > 0) begin
            stall_left--;
        end else begin
            stall_on   = ($urandom_range(0, 2) == 0);
            stall_left = $urandom_range(0, 5);
        end
        rs_stall = stall_force || (stall_rand && stall_on);
    endtask

    // one edge, then the pulse inputs drop.
    task automatic next_cycle();
        @(posedge clk);
        took = valid && ready;
        #10;
        rob_free = 1'b0;
        ldq_free = 1'b0;
        stq_free = 1'b0;
        nuke     = 1'b0;
        drive_stall();
    endtask

    task automatic send_uop(input t_opcode op, input int d, input int s1, input int s2);
        int waited;
        valid  = 1'b1;
        opcode = op;
        dst    = reg_addr_w'(d);
        src1   = reg_addr_w'(s1);
        src2   = reg_addr_w'(s2);
        waited = 0;
        next_cycle();
        while (!took && waited < accept_limit) begin
            next_cycle();
            waited++;
        end
        if (!took) begin
            $display("%0t: op was not accepted within %0d cycles", $time, accept_limit);
            errors++;
        end
        valid = 1'b0;
    endtask

    // retire everything that is still allocated.
    task automatic drain_all();
        int n;
        valid       = 1'b0;
        stall_rand  = 1'b0;
        stall_force = 1'b0;
        n           = 0;
        do begin
            rob_free = (ref_rob_cnt > 0);
            ldq_free = (ref_ldq_cnt > 0);
            stq_free = (ref_stq_cnt > 0);
            next_cycle();
            n++;
        end while ((ref_rob_cnt + ref_ldq_cnt + ref_stq_cnt + ref_q.size()) != 0
                   && n < drain_limit);
        if ((ref_rob_cnt + ref_ldq_cnt + ref_stq_cnt + ref_q.size()) != 0) begin
            $display("%0t: backend did not drain within %0d cycles", $time, drain_limit);
            errors++;
        end
    endtask

    task automatic finish_test(input int num, input string name);
        $display("test %0d %s: %0d errors", num, name, errors - test_errors);
        test_errors = errors;
    endtask

    // hold an op against a full structure, then free one entry.
    task automatic full_hold(input t_opcode op, input logic is_rob);
        valid  = 1'b1;
        opcode = op;
        dst    = 5'd9;
        src1   = 5'd1;
        src2   = 5'd2;
        repeat (5) begin
            next_cycle();
            check_value("ready", took, 1'b0);
        end
        rob_free = is_rob;
        ldq_free = !is_rob;
        next_cycle();
        check_value("ready", took, 1'b0);
        next_cycle();
        check_value("ready", took, 1'b1);
        valid = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // tests.
    ////////////////////////////////////////////////////////////

    initial begin
        void'($urandom(run_seed));
        reset    = 1'b1;
        valid    = 1'b0;
        opcode   = op_alu;
        dst      = '0;
        src1     = '0;
        src2     = '0;
        rs_stall = 1'b0;
        nuke     = 1'b0;
        rob_free = 1'b0;
        ldq_free = 1'b0;
        stq_free = 1'b0;
        repeat (4) @(posedge clk);
        #10;
        reset = 1'b0;

        send_uop(op_alu, 1, 0, 0);
        send_uop(op_alu, 2, 1, 0);
        send_uop(op_alu, 3, 1, 2);
        send_uop(op_alu, 1, 1, 3);
        send_uop(op_alu, 0, 1, 2);
        send_uop(op_alu, 4, 0, 4);
        send_uop(op_branch, 0, 4, 1);
        send_uop(op_alu, 2, 2, 2);
        send_uop(op_alu, 5, 3, 2);
        send_uop(op_alu, 0, 0, 5);
        drain_all();
        finish_test(1, "rename chains");

        for (int i = 0; i < 36; i++) begin
            rob_free = (ref_rob_cnt > 0);
            ldq_free = (ref_ldq_cnt > 2);
            stq_free = (ref_stq_cnt > 1);
            send_uop(t_opcode'((i % 3 == 0) ? op_load : (i % 3 == 1) ? op_store : op_alu),
                     i % 8, (i + 3) % 8, 0);
        end
        drain_all();
        finish_test(2, "memory ids");

        stall_rand = 1'b1;
        for (int i = 0; i < 24; i++) begin
            rob_free = (ref_rob_cnt > 0);
            ldq_free = (ref_ldq_cnt > 0);
            stq_free = (ref_stq_cnt > 0);
            send_uop(t_opcode'($urandom_range(0, 3)), $urandom_range(0, 7),
                     $urandom_range(0, 7), $urandom_range(0, 7));
        end
        drain_all();
        finish_test(3, "back-pressure");

        repeat (num_ldq) send_uop(op_load, 6, 1, 2);
        full_hold(op_load, 1'b0);
        drain_all();
        repeat (num_rob) send_uop(op_alu, 8, 0, 0);
        full_hold(op_alu, 1'b1);
        drain_all();
        finish_test(4, "full stalls");

        send_uop(op_alu, 1, 0, 0);
        send_uop(op_load, 2, 1, 0);
        send_uop(op_store, 0, 2, 1);
        // the store stays in the stage.
        stall_force = 1'b1;
        rs_stall    = 1'b1;
        next_cycle();
        next_cycle();
        nuke = 1'b1;
        next_cycle();
        stall_force = 1'b0;
        rs_stall    = 1'b0;
        next_cycle();
        send_uop(op_load, 4, 1, 2);
        send_uop(op_store, 5, 4, 2);
        drain_all();
        finish_test(5, "nuke");

        stall_rand = 1'b1;
        repeat (random_cycles) begin
            valid    = $urandom_range(0, 1);
            opcode   = t_opcode'($urandom_range(0, 3));
            dst      = reg_addr_w'($urandom_range(0, num_arch_regs - 1));
            src1     = reg_addr_w'($urandom_range(0, num_arch_regs - 1));
            src2     = reg_addr_w'($urandom_range(0, num_arch_regs - 1));
            rob_free = (ref_rob_cnt > 0) && ($urandom_range(0, 2) == 0);
            ldq_free = (ref_ldq_cnt > 0) && ($urandom_range(0, 2) == 0);
            stq_free = (ref_stq_cnt > 0) && ($urandom_range(0, 2) == 0);
            next_cycle();
        end
        drain_all();
        finish_test(6, "random mix");

        $display("tests: 6, checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        #(watchdog_cycles * clk_period);
        $display("watchdog expired after %0d cycles, the tests did not finish",
                 watchdog_cycles);
        $display("sim failed");
        $finish;
    end

endmodule

// File: list.f
+incdir+tb
src/alloc_pkg.sv
src/rename.sv
src/mem_id_trk.sv
src/alloc.sv
src/alloc_top.sv
tb/alloc_tb.sv
